/* hw/pce_input_pkg.sv */
////////////////////////////////////////
// Shared widths, types and limits for the
// PC Engine controller-port input path.
// Imported inside each module body.
////////////////////////////////////////

`default_nettype none

package pce_input_pkg;

	////////////////////////////////////////
	// Pad words
	////////////////////////////////////////

	// Directions, I, II, Select, Run, III..VI
	localparam int PAD_BITS = 12;

	// Ports on the multitap
	localparam int PORT_COUNT = 5;

	// Bit set means pressed
	// 3:0 up/down/left/right, 7:4 Run/Select/II/I, 11:8 VI..III
	typedef logic [PAD_BITS-1:0] pad_t;

	// One console read
	typedef logic [3:0] nibble_t;

	// Port index, 5..7 reads as an empty port
	typedef logic [2:0] port_idx_t;

	// Empty port nibble
	localparam nibble_t NO_PAD_NIBBLE = 4'hF;

	////////////////////////////////////////
	// Mouse
	////////////////////////////////////////

	typedef logic [1:0] mouse_nib_t;
	typedef logic [7:0] mouse_delta_t;

	// Strobe toggles once per packet; flags[0] left, flags[1] right
	typedef struct packed {
		logic         strobe;
		mouse_delta_t dy;
		mouse_delta_t dx;
		logic [7:0]   flags;
	} ps2_mouse_t;

	// CLR low this long puts the scan counter back to its last nibble
	localparam int MOUSE_IDLE_LIMIT = 32767;
	localparam int IDLE_BITS = $clog2(MOUSE_IDLE_LIMIT + 1);
	typedef logic [IDLE_BITS-1:0] idle_cnt_t;

endpackage

`default_nettype wire

/* hw/pad_bus_if.sv */
////////////////////////////////////////
// Scan state from the port sequencer to
// the encoder and the mouse tracker.
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface pad_bus_if;
	import pce_input_pkg::*;

	// Registered strobe levels
	logic       clr;
	logic       sel;

	port_idx_t  port_sel;
	logic       high_bank;
	mouse_nib_t mouse_nib;

	// Single cycle pulses
	logic       mouse_commit;
	logic       scan_start;

	modport seq (output clr, sel, port_sel, high_bank, mouse_nib, mouse_commit, scan_start);

	modport dp (input clr, sel, port_sel, high_bank, mouse_nib, mouse_commit, scan_start);

endinterface

`default_nettype wire

/* hw/port_sequencer.sv */
////////////////////////////////////////
// Follows the console CLR/SEL strobes and
// owns the scan state: multitap port, six
// button bank, mouse nibble and idle timer.
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module port_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic clr,
	input  logic sel,
	input  logic tap_en,
	input  logic six_button_en,
	pad_bus_if.seq bus
);
	import pce_input_pkg::*;

	logic       clr_q;
	logic       sel_q;
	logic       clr_rise;
	logic       sel_rise;

	port_idx_t  port_q;
	logic       bank_q;
	mouse_nib_t nib_q;
	logic       commit_q;
	logic       scan_q;
	idle_cnt_t  idle_cnt;
	logic       idle_hit;

	// Edges against last cycle's sample
	assign clr_rise = clr & ~clr_q;
	assign sel_rise = sel & ~sel_q;

	assign idle_hit = (idle_cnt == idle_cnt_t'(MOUSE_IDLE_LIMIT));

	////////////////////////////////////////
	// Strobe sampling and idle timer
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_q    <= 1'b0;
			sel_q    <= 1'b0;
			idle_cnt <= '0;
		end else begin
			clr_q <= clr;
			sel_q <= sel;
			// Saturates until CLR comes back
			if (clr)
				idle_cnt <= '0;
			else if (!idle_hit)
				idle_cnt <= idle_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Scan state
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_q   <= '0;
			bank_q   <= 1'b0;
			nib_q    <= 2'd3;
			commit_q <= 1'b0;
			scan_q   <= 1'b0;
		end else begin
			scan_q   <= clr_rise;
			commit_q <= clr_rise && (nib_q == 2'd3);

			// Resync first, a new scan on the same cycle still advances
			if (idle_hit)
				nib_q <= 2'd3;
			if (clr_rise) begin
				bank_q <= ~bank_q & six_button_en;
				nib_q  <= nib_q + 2'd1;
			end

			// Multitap stepping, stops at the last index
			if (clr)
				port_q <= '0;
			else if (sel_rise && tap_en && (port_q != '1))
				port_q <= port_q + 3'd1;
		end
	end

	assign bus.clr          = clr_q;
	assign bus.sel          = sel_q;
	assign bus.port_sel     = port_q;
	assign bus.high_bank    = bank_q;
	assign bus.mouse_nib    = nib_q;
	assign bus.mouse_commit = commit_q;
	assign bus.scan_start   = scan_q;

endmodule

`default_nettype wire

/* hw/pad_encoder.sv */
////////////////////////////////////////
// Picks the nibble the console reads for
// the current port, bank and SEL level,
// and registers it onto the port lines.
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module pad_encoder (
	input  logic                    clk_sys,
	input  logic                    reset,
	pad_bus_if.dp                   bus,
	input  logic                    mouse_en,
	input  pce_input_pkg::pad_t     pad0,
	input  pce_input_pkg::pad_t     pad1,
	input  pce_input_pkg::pad_t     pad2,
	input  pce_input_pkg::pad_t     pad3,
	input  pce_input_pkg::pad_t     pad4,
	input  logic [1:0]              ps2_buttons,
	input  pce_input_pkg::nibble_t  move_nibble,
	output pce_input_pkg::nibble_t  port_nibble
);
	import pce_input_pkg::*;

	pad_t    pads [PORT_COUNT];
	pad_t    cur_pad;
	nibble_t next_nibble;

	// Console lines are active low
	function automatic nibble_t pad_nibble(input pad_t p, input logic high, input logic s);
		nibble_t n;
		case ({high, s})
			2'b00:   n = ~p[7:4];
			2'b01:   n = ~{p[1], p[2], p[0], p[3]};
			2'b10:   n = ~p[11:8];
			default: n = 4'h0;
		endcase
		return n;
	endfunction

	assign pads[0] = pad0;
	assign pads[1] = pad1;
	assign pads[2] = pad2;
	assign pads[3] = pad3;
	assign pads[4] = pad4;

	always_comb begin
		cur_pad = pads[0];
		for (int i = 1; i < PORT_COUNT; i++) begin
			if (bus.port_sel == port_idx_t'(i))
				cur_pad = pads[i];
		end
	end

	////////////////////////////////////////
	// Nibble select
	////////////////////////////////////////

	always_comb begin
		if (bus.port_sel >= port_idx_t'(PORT_COUNT))
			next_nibble = NO_PAD_NIBBLE;
		else if (mouse_en && (bus.port_sel == '0))
			// Mouse ignores the bank
			next_nibble = bus.sel ? move_nibble : ~{pad0[7], pad0[6], ps2_buttons[1], ps2_buttons[0]};
		else
			next_nibble = pad_nibble(cur_pad, bus.high_bank, bus.sel);
	end

	always_ff @(posedge clk_sys) begin
		if (reset || bus.clr)
			port_nibble <= '0;
		else
			port_nibble <= next_nibble;
	end

endmodule

`default_nettype wire

/* hw/mouse_tracker.sv */
////////////////////////////////////////
// Collects PS/2 mouse deltas between scans
// and hands the committed pair out one
// nibble per CLR scan.
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mouse_tracker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  pce_input_pkg::ps2_mouse_t ps2_mouse,
	pad_bus_if.dp                     bus,
	output pce_input_pkg::nibble_t    move_nibble
);
	import pce_input_pkg::*;

	logic         strobe_q;
	logic         new_packet;

	// Deltas gathered since the last commit
	mouse_delta_t pend_x;
	mouse_delta_t pend_y;

	// Deltas the console is reading now
	mouse_delta_t ms_x;
	mouse_delta_t ms_y;

	// Strobe level one cycle back
	always_ff @(posedge clk_sys) begin
		strobe_q <= ps2_mouse.strobe;
	end

	assign new_packet = strobe_q ^ ps2_mouse.strobe;

	////////////////////////////////////////
	// Pending and committed deltas
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pend_x <= '0;
			pend_y <= '0;
			ms_x   <= '0;
			ms_y   <= '0;
		end else begin
			if (bus.mouse_commit) begin
				ms_x   <= pend_x;
				ms_y   <= pend_y;
				pend_x <= '0;
				pend_y <= '0;
			end
			// A packet landing on a commit starts the next pair
			if (new_packet) begin
				pend_x <= 8'd0 - ps2_mouse.dx;
				pend_y <= ps2_mouse.dy;
			end
		end
	end

	////////////////////////////////////////
	// Movement nibble
	////////////////////////////////////////

	always_comb begin
		case (bus.mouse_nib)
			2'd0:    move_nibble = ms_x[7:4];
			2'd1:    move_nibble = ms_x[3:0];
			2'd2:    move_nibble = ms_y[7:4];
			default: move_nibble = ms_y[3:0];
		endcase
	end

endmodule

`default_nettype wire

/* hw/pce_input_top.sv */
////////////////////////////////////////
// Controller-port input path top level.
// Takes the console CLR/SEL strobes, pads
// and PS/2 mouse, returns the read nibble.
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module pce_input_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      clr,
	input  logic                      sel,
	input  logic                      tap_en,
	input  logic                      six_button_en,
	input  logic                      mouse_en,
	input  pce_input_pkg::pad_t       pad0,
	input  pce_input_pkg::pad_t       pad1,
	input  pce_input_pkg::pad_t       pad2,
	input  pce_input_pkg::pad_t       pad3,
	input  pce_input_pkg::pad_t       pad4,
	input  pce_input_pkg::ps2_mouse_t ps2_mouse,
	output pce_input_pkg::nibble_t    port_nibble
);
	import pce_input_pkg::*;

	nibble_t move_nibble;

	pad_bus_if bus_i ();

	port_sequencer port_sequencer_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.clr           (clr),
		.sel           (sel),
		.tap_en        (tap_en),
		.six_button_en (six_button_en),
		.bus           (bus_i.seq)
	);

	mouse_tracker mouse_tracker_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_mouse   (ps2_mouse),
		.bus         (bus_i.dp),
		.move_nibble (move_nibble)
	);

	// Buttons go straight to the encoder, deltas through the tracker
	pad_encoder pad_encoder_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus_i.dp),
		.mouse_en    (mouse_en),
		.pad0        (pad0),
		.pad1        (pad1),
		.pad2        (pad2),
		.pad3        (pad3),
		.pad4        (pad4),
		.ps2_buttons (ps2_mouse.flags[1:0]),
		.move_nibble (move_nibble),
		.port_nibble (port_nibble)
	);

endmodule

`default_nettype wire

/* test/tb_model.svh */
////////////////////////////////////////
// Reference rules for the testbench. The
// random source and the nibble that the
// console should read for a scan state.
////////////////////////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Galois form with taps 32 30 26 25
// Bit 0 is the bit taken before each step
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'hA300_0000;
	return s >> 1;
endfunction

// Two or six button pad, lines are active low
function automatic nibble_t pad_read(input pad_t p, input logic high, input logic sel_hi);
	logic up;
	logic down;
	logic left;
	logic right;
	up = p[3];
	down = p[2];
	left = p[1];
	right = p[0];
	if (high)
		return sel_hi ? 4'h0 : ~p[11:8];
	if (sel_hi)
		return ~{left, down, right, up};
	return ~p[7:4];
endfunction

// Movement nibbles in scan order
function automatic nibble_t mouse_read(input mouse_nib_t nib, input mouse_delta_t x,
	input mouse_delta_t y);
	case (nib)
		2'd0:    return x[7:4];
		2'd1:    return x[3:0];
		2'd2:    return y[7:4];
		default: return y[3:0];
	endcase
endfunction

function automatic nibble_t expect_nibble(
	input logic         clr_hi,
	input logic         sel_hi,
	input logic         mouse,
	input port_idx_t    port,
	input logic         bank,
	input mouse_nib_t   nib,
	input pad_t         pad,
	input pad_t         pad0,
	input logic [1:0]   buttons,
	input mouse_delta_t x,
	input mouse_delta_t y
);
	// Lines sit low for the whole CLR pulse
	if (clr_hi)
		return 4'h0;
	if (port >= 3'd5)
		return 4'hF;
	if (mouse && port == 3'd0) begin
		if (sel_hi)
			return mouse_read(nib, x, y);
		// Run, Select, right button, left button
		return ~{pad0[7], pad0[6], buttons[1], buttons[0]};
	end
	return pad_read(pad, bank, sel_hi);
endfunction

`endif

/* test/tb_pce_input.sv */
////////////////////////////////////////
// Testbench for the controller-port path.
// Applies a table of CLR/SEL/mouse actions
// and compares port_nibble with a model.
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_pce_input;
	import pce_input_pkg::*;
	`include "tb_model.svh"

	localparam logic [2:0] ACT_CLR       = 3'd0;
	localparam logic [2:0] ACT_SEL_PULSE = 3'd1;
	localparam logic [2:0] ACT_SEL       = 3'd2;
	localparam logic [2:0] ACT_PACKET    = 3'd3;
	localparam logic [2:0] ACT_IDLE      = 3'd4;
	localparam logic [2:0] ACT_PADS      = 3'd5;

	// arg is a repeat count, a SEL level or idle cycles
	typedef struct packed {
		logic [2:0]  id;
		logic        tap;
		logic        six;
		logic        mouse;
		logic [2:0]  act;
		logic [15:0] arg;
		logic        chk;
	} row_t;

	localparam logic [15:0] IDLE_ROW = 16'(MOUSE_IDLE_LIMIT + 16);
	localparam int NUM_ROWS = 30;
	localparam row_t ROWS [NUM_ROWS] = '{
		'{3'd1, 1'b0, 1'b0, 1'b0, ACT_CLR,       16'd2, 1'b1},
		'{3'd2, 1'b0, 1'b0, 1'b0, ACT_SEL,       16'd1, 1'b1},
		'{3'd2, 1'b0, 1'b0, 1'b0, ACT_SEL,       16'd0, 1'b1},
		'{3'd2, 1'b0, 1'b0, 1'b0, ACT_PADS,      16'd0, 1'b0},
		'{3'd2, 1'b0, 1'b0, 1'b0, ACT_SEL,       16'd1, 1'b1},
		'{3'd2, 1'b0, 1'b0, 1'b0, ACT_SEL_PULSE, 16'd2, 1'b1},
		'{3'd3, 1'b1, 1'b0, 1'b0, ACT_CLR,       16'd1, 1'b1},
		'{3'd3, 1'b1, 1'b0, 1'b0, ACT_SEL_PULSE, 16'd8, 1'b1},
		'{3'd3, 1'b1, 1'b0, 1'b0, ACT_CLR,       16'd1, 1'b1},
		'{3'd3, 1'b1, 1'b0, 1'b0, ACT_SEL_PULSE, 16'd2, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_CLR,       16'd1, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_SEL_PULSE, 16'd1, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_CLR,       16'd1, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_SEL_PULSE, 16'd1, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_PADS,      16'd0, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_CLR,       16'd1, 1'b1},
		'{3'd4, 1'b0, 1'b1, 1'b0, ACT_SEL_PULSE, 16'd1, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_SEL,       16'd1, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_PACKET,    16'd0, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_CLR,       16'd4, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_PACKET,    16'd0, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_CLR,       16'd5, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_SEL,       16'd0, 1'b1},
		'{3'd5, 1'b0, 1'b0, 1'b1, ACT_PACKET,    16'd0, 1'b1},
		'{3'd6, 1'b0, 1'b0, 1'b1, ACT_SEL,       16'd1, 1'b1},
		'{3'd6, 1'b0, 1'b0, 1'b1, ACT_PACKET,    16'd0, 1'b1},
		'{3'd6, 1'b0, 1'b0, 1'b1, ACT_CLR,       16'd1, 1'b1},
		'{3'd6, 1'b0, 1'b0, 1'b1, ACT_PACKET,    16'd0, 1'b1},
		'{3'd6, 1'b0, 1'b0, 1'b1, ACT_IDLE,      IDLE_ROW, 1'b1},
		'{3'd6, 1'b0, 1'b0, 1'b1, ACT_CLR,       16'd2, 1'b1}
	};
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 2 * MOUSE_IDLE_LIMIT;

	logic       clk_sys = 1'b0;
	logic       reset = 1'b1;
	logic       clr = 1'b0;
	logic       sel = 1'b0;
	logic       tap_en = 1'b0;
	logic       six_button_en = 1'b0;
	logic       mouse_en = 1'b0;
	pad_t       pads [PORT_COUNT];
	ps2_mouse_t ps2_mouse = '0;
	nibble_t    port_nibble;

	// Model of the scan state
	port_idx_t    m_port = '0;
	logic         m_bank = 1'b0;
	mouse_nib_t   m_nib = 2'd3;
	logic         m_clr = 1'b0;
	logic         m_sel = 1'b0;
	mouse_delta_t m_pend_x = '0;
	mouse_delta_t m_pend_y = '0;
	mouse_delta_t m_ms_x = '0;
	mouse_delta_t m_ms_y = '0;

	logic [31:0] lfsr_state = 32'ha58d_5557;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	int tests_run = 0;
	int failed_tests = 0;

	pce_input_top pce_input_top_i (
		.*,
		.pad0 (pads[0]),
		.pad1 (pads[1]),
		.pad2 (pads[2]),
		.pad3 (pads[3]),
		.pad4 (pads[4])
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic new_pads();
		logic [31:0] v;
		for (int i = 0; i < PORT_COUNT; i++) begin
			draw(PAD_BITS, v);
			pads[i] = v[PAD_BITS-1:0];
		end
	endtask

	// Multitap steps on SEL rising with CLR low
	task automatic set_sel(input logic level, input logic tap);
		if (level && !m_sel && tap && !m_clr && m_port != 3'd7)
			m_port = m_port + 3'd1;
		m_sel = level;
		sel = level;
	endtask

	// Output follows an input change within three cycles
	task automatic settle(input logic chk, input string what);
		pad_t    cur;
		nibble_t exp;
		repeat (3) @(posedge clk_sys);
		#1;
		if (chk) begin
			cur = (m_port < 3'd5) ? pads[m_port] : '0;
			exp = expect_nibble(m_clr, m_sel, mouse_en, m_port, m_bank, m_nib, cur,
				pads[0], ps2_mouse.flags[1:0], m_ms_x, m_ms_y);
			checks++;
			test_checks++;
			if (port_nibble !== exp) begin
				$display("Mismatch at %0t: port_nibble got %h, expected %h after %s",
					$time, port_nibble, exp, what);
				errors++;
				test_errors++;
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] v;
		tap_en = r.tap;
		six_button_en = r.six;
		mouse_en = r.mouse;
		case (r.act)
			ACT_CLR: begin
				repeat (r.arg) begin
					clr = 1'b1;
					m_clr = 1'b1;
					// Wrapping past the last nibble commits the deltas
					if (m_nib == 2'd3) begin
						m_ms_x = m_pend_x;
						m_ms_y = m_pend_y;
						m_pend_x = '0;
						m_pend_y = '0;
					end
					m_nib = m_nib + 2'd1;
					// Bank flips per scan in six button mode
					if (r.six)
						m_bank = ~m_bank;
					else
						m_bank = 1'b0;
					m_port = '0;
					settle(r.chk, "CLR high");
					clr = 1'b0;
					m_clr = 1'b0;
					settle(r.chk, "CLR low");
				end
			end
			ACT_SEL_PULSE: begin
				repeat (r.arg) begin
					set_sel(1'b1, r.tap);
					settle(r.chk, "SEL high");
					set_sel(1'b0, r.tap);
					settle(r.chk, "SEL low");
				end
			end
			ACT_SEL: begin
				set_sel(r.arg[0], r.tap);
				settle(r.chk, "SEL level");
			end
			ACT_PACKET: begin
				draw(18, v);
				ps2_mouse = {~ps2_mouse.strobe, v[17:10], v[9:2], 6'd0, v[1:0]};
				m_pend_x = 8'd0 - v[9:2];
				m_pend_y = v[17:10];
				settle(r.chk, "mouse packet");
			end
			ACT_IDLE: begin
				repeat (r.arg) @(posedge clk_sys);
				if (r.arg > MOUSE_IDLE_LIMIT)
					m_nib = 2'd3;
				settle(r.chk, "CLR idle");
			end
			default: begin
				new_pads();
				settle(r.chk, "new pads");
			end
		endcase
	endtask

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "reset and CLR";
			3'd2:    return "single pad";
			3'd3:    return "multitap";
			3'd4:    return "six button";
			3'd5:    return "mouse";
			default: return "mouse resync";
		endcase
	endfunction

	initial begin
		new_pads();
		repeat (2) @(posedge clk_sys);
		#1;
		checks++;
		test_checks++;
		if (port_nibble !== 4'h0) begin
			$display("Mismatch at %0t: port_nibble got %h, expected 0 in reset",
				$time, port_nibble);
			errors++;
			test_errors++;
		end
		reset = 1'b0;

		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(ROWS[i]);
			if (i == NUM_ROWS - 1 || ROWS[i + 1].id != ROWS[i].id) begin
				$display("Test %0d %s: %0d checks, %0d errors", ROWS[i].id,
					test_name(ROWS[i].id), test_checks, test_errors);
				tests_run++;
				if (test_errors != 0)
					failed_tests++;
				test_checks = 0;
				test_errors = 0;
			end
		end

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, failed_tests,
			checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* pce_input.f */
+incdir+test
hw/pce_input_pkg.sv
hw/pad_bus_if.sv
hw/port_sequencer.sv
hw/pad_encoder.sv
hw/mouse_tracker.sv
hw/pce_input_top.sv
test/tb_pce_input.sv

/* Makefile */
# Verilator build and run of the controller-port testbench

TOP := tb_pce_input

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f pce_input.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
